//--- bench/put_golden.txt
// columns: ea ctxt aux beats last_count rc data_seed expected_tsize (hex)
// one transfer per line, a last_count of 0 means a full 16-byte end beat
0000000000001000 01a 1 1 4 0 11110000 04
00000000deadbe00 0ff 0 2 0 0 22220000 20
0000123400000080 100 1 8 0 0 33330000 80
00000000cafe0000 003 0 3 7 1 44440000 27
7fff000000000000 1ff 1 5 f 0 55550000 4f
0000000000000040 000 0 1 0 0 66660000 10
0000000100000000 0aa 1 4 1 1 77770000 31
00000000beef0040 155 0 6 8 0 88880000 58
0000abcd00001000 012 1 7 2 0 99990000 62
0000000000002000 034 0 2 9 0 aaaa0000 19
0000000000003000 056 1 8 c 1 bbbb0000 7c
0000fedc00000000 078 0 1 3 0 cccc0000 03
0000000012345600 09a 1 3 0 0 dddd0000 30
00000000000a0000 0bc 0 4 a 0 eeee0000 3a
00000000000b0000 0de 1 5 5 1 ffff0000 45
0000000000c00000 0f0 0 6 0 0 01020000 60
000000000d000000 111 1 2 6 0 03040000 16
00000000e0000000 122 0 7 e 0 05060000 6e
0000000f00000000 133 1 1 1 0 07080000 01
0000001000000000 144 0 3 b 1 090a0000 2b

//--- build.f
+incdir+include
hw/put_pkg.sv
hw/put_tag_pool.sv
hw/put_data_stage.sv
hw/put_data_buffer.sv
hw/put_req_issue.sv
hw/put_rsp_tracker.sv
hw/put_engine.sv
bench/put_engine_tb.sv

//--- Makefile
# Verilator flow for the put engine

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= put_engine_tb
RTL_TOP   ?= put_engine
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/put_engine_tb.sv
// put engine testbench
// golden-file transfers through the engine with random bus stalls,
// buffer read-back, foreign uid filtering and done checks
`default_nettype none

`include "put_macros.svh"

module put_engine_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_VEC = 20;
   localparam int BATCH   = 4;
   localparam int LIMIT   = 200;
   localparam logic [`PUT_UID_W-1:0] OWN_UID = `PUT_UID_W'(`PUT_UID);

   // one golden line
   typedef struct packed {
      logic [`PUT_EA_W-1:0]    ea;
      logic [`PUT_CTXT_W-1:0]  ctxt;
      logic [`PUT_AUX_W-1:0]   aux;
      logic [3:0]              beats;
      logic [3:0]              last;
      logic [`PUT_RC_W-1:0]    rc;
      logic [31:0]             seed;
      logic [`PUT_TSIZE_W-1:0] tsize;
   } vec_t;

   logic                    clk = 1'b0;
   logic                    i_rst_n;
   logic                    put_addr_v;
   put_pkg::put_addr_t      put_addr_d;
   logic                    put_addr_r;
   logic                    put_data_v;
   logic                    put_data_r;
   logic [`PUT_DATA_W-1:0]  put_data_d;
   logic                    put_data_e;
   logic [3:0]              put_data_c;
   logic                    o_req_v;
   put_pkg::put_req_t       o_req_d;
   logic                    o_req_r = 1'b0;
   logic                    i_rsp_v;
   put_pkg::put_rsp_t       i_rsp_d;
   logic                    i_wdata_req_v;
   put_pkg::put_wdata_req_t i_wdata_req_a;
   logic                    o_wdata_rsp_v;
   logic [`PUT_DATA_W-1:0]  o_wdata_rsp_d;
   logic                    put_done_v;
   put_pkg::put_done_t      put_done_d;
   logic                    put_done_r;

   logic [63:0]           raw [NUM_VEC * 8];
   vec_t                  vecs [NUM_VEC];
   logic [`PUT_TAG_W-1:0] tag_of [NUM_VEC];
   put_pkg::put_req_t     req_q [$];
   // last slot belongs to the reset test
   int                    test_err [NUM_VEC + 1];
   int                    cur;
   bit                    timed_out;

   put_engine u_put_engine (
      .clk(clk), .i_rst_n(i_rst_n),
      .put_addr_v(put_addr_v), .put_addr_d(put_addr_d), .put_addr_r(put_addr_r),
      .put_data_v(put_data_v), .put_data_r(put_data_r), .put_data_d(put_data_d),
      .put_data_e(put_data_e), .put_data_c(put_data_c),
      .o_req_v(o_req_v), .o_req_d(o_req_d), .o_req_r(o_req_r),
      .i_rsp_v(i_rsp_v), .i_rsp_d(i_rsp_d),
      .i_wdata_req_v(i_wdata_req_v), .i_wdata_req_a(i_wdata_req_a),
      .o_wdata_rsp_v(o_wdata_rsp_v), .o_wdata_rsp_d(o_wdata_rsp_d),
      .put_done_v(put_done_v), .put_done_d(put_done_d), .put_done_r(put_done_r)
   );

   always #50 clk = ~clk;

   // bus side of the request handshake, ready stalls at random
   always @(posedge clk) begin
      if (o_req_v && o_req_r) begin
         req_q.push_back(o_req_d);
      end
      o_req_r <= ($urandom_range(3) != 0);
   end

   function automatic logic [`PUT_DATA_W-1:0] beat_data(int v, int b);
      return {4{vecs[v].seed + 32'(b)}};
   endfunction

   task automatic compare_value(string name, logic [127:0] got, logic [127:0] exp);
      assert (got === exp) else begin
         $display("mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
         test_err[cur]++;
      end
   endtask

   task automatic note_failure(string what);
      $display("error at %0d ns: %s", $time, what);
      test_err[cur]++;
      timed_out = 1'b1;
   endtask

   task automatic send_transfer(int v);
      int n;
      int nb;
      bit done;
      cur = v;
      nb  = int'(vecs[v].beats);
      put_addr_v      <= 1'b1;
      put_addr_d.aux  <= vecs[v].aux;
      put_addr_d.ctxt <= vecs[v].ctxt;
      put_addr_d.ea   <= vecs[v].ea;
      n    = 0;
      done = 1'b0;
      while (!done && n < LIMIT) begin
         @(posedge clk);
         n++;
         done = put_addr_r;
      end
      put_addr_v <= 1'b0;
      if (!done) begin
         note_failure("timeout waiting for put_addr_r");
         return;
      end
      for (int b = 0; b < nb; b++) begin
         put_data_v <= 1'b1;
         put_data_d <= beat_data(v, b);
         put_data_e <= (b == nb - 1);
         put_data_c <= (b == nb - 1) ? vecs[v].last : 4'd0;
         n    = 0;
         done = 1'b0;
         while (!done && n < LIMIT) begin
            @(posedge clk);
            n++;
            done = put_data_r;
         end
         if (!done) begin
            put_data_v <= 1'b0;
            note_failure("timeout waiting for put_data_r");
            return;
         end
      end
      put_data_v <= 1'b0;
      put_data_e <= 1'b0;
   endtask

   // requests arrive from the bus model in issue order
   task automatic check_request(int v);
      int                n;
      put_pkg::put_req_t req;
      cur = v;
      n   = 0;
      while (req_q.size() == 0 && n < LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (req_q.size() == 0) begin
         note_failure("timeout waiting for o_req_v");
         return;
      end
      req       = req_q.pop_front();
      tag_of[v] = req.tag;
      compare_value("o_req_d.ea", 128'(req.ea), 128'(vecs[v].ea));
      compare_value("o_req_d.ctxt", 128'(req.ctxt), 128'(vecs[v].ctxt));
      compare_value("o_req_d.aux", 128'(req.aux), 128'(vecs[v].aux));
      compare_value("o_req_d.uid", 128'(req.uid), 128'(OWN_UID));
      compare_value("o_req_d.tsize", 128'(req.tsize), 128'(vecs[v].tsize));
   endtask

   // one read per beat, then a read with a foreign uid that must stay silent
   task automatic read_back(int v);
      int nb;
      cur = v;
      nb  = int'(vecs[v].beats);
      for (int b = 0; b <= nb; b++) begin
         i_wdata_req_v      <= 1'b1;
         i_wdata_req_a.uid  <= (b == nb) ? ~OWN_UID : OWN_UID;
         i_wdata_req_a.tag  <= tag_of[v];
         i_wdata_req_a.beat <= `PUT_BEAT_W'(b % `PUT_MAX_BEATS);
         @(posedge clk);
         i_wdata_req_v <= 1'b0;
         @(posedge clk);
         if (b == nb) begin
            compare_value("o_wdata_rsp_v", 128'(o_wdata_rsp_v), 128'(0));
         end else begin
            compare_value("o_wdata_rsp_v", 128'(o_wdata_rsp_v), 128'(1));
            compare_value("o_wdata_rsp_d", o_wdata_rsp_d, beat_data(v, b));
         end
      end
   endtask

   task automatic send_response(int v, bit foreign);
      int gap;
      gap = int'($urandom_range(3));
      repeat (gap) @(posedge clk);
      i_rsp_v     <= 1'b1;
      i_rsp_d.rc  <= vecs[v].rc;
      i_rsp_d.uid <= foreign ? ~OWN_UID : OWN_UID;
      i_rsp_d.tag <= tag_of[v];
      @(posedge clk);
      i_rsp_v <= 1'b0;
   endtask

   task automatic collect_done(int v);
      int                     n;
      bit                     done;
      put_pkg::put_done_t     got;
      logic [`PUT_BCNT_W-1:0] exp_bcnt;
      cur  = v;
      n    = 0;
      done = 1'b0;
      while (!done && n < LIMIT) begin
         put_done_r <= ($urandom_range(3) != 0);
         @(posedge clk);
         n++;
         done = put_done_v & put_done_r;
         if (done) begin
            got = put_done_d;
         end
      end
      put_done_r <= 1'b0;
      if (!done) begin
         note_failure("timeout waiting for put_done_v");
         return;
      end
      exp_bcnt = (vecs[v].rc == '0) ? `PUT_BCNT_W'(vecs[v].tsize) : '0;
      compare_value("put_done_d.rc", 128'(got.rc), 128'(vecs[v].rc));
      compare_value("put_done_d.bcnt", 128'(got.bcnt), 128'(exp_bcnt));
   endtask

   task automatic report_test(string name, int idx);
      if (test_err[idx] == 0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d check(s) wrong", name, test_err[idx]);
      end
   endtask

   initial begin
      int order [$];
      int idx;
      int v;
      int passed;
      int total;
      void'($urandom(32'hfb411bd9));
      i_rst_n       = 1'b0;
      put_addr_v    = 1'b0;
      put_addr_d    = '0;
      put_data_v    = 1'b0;
      put_data_d    = '0;
      put_data_e    = 1'b0;
      put_data_c    = 4'd0;
      i_rsp_v       = 1'b0;
      i_rsp_d       = '0;
      i_wdata_req_v = 1'b0;
      i_wdata_req_a = '0;
      put_done_r    = 1'b0;
      timed_out     = 1'b0;
      $readmemh("bench/put_golden.txt", raw);
      for (int k = 0; k < NUM_VEC; k++) begin
         vecs[k].ea    = raw[k*8];
         vecs[k].ctxt  = raw[k*8+1][`PUT_CTXT_W-1:0];
         vecs[k].aux   = raw[k*8+2][`PUT_AUX_W-1:0];
         vecs[k].beats = raw[k*8+3][3:0];
         vecs[k].last  = raw[k*8+4][3:0];
         vecs[k].rc    = raw[k*8+5][`PUT_RC_W-1:0];
         vecs[k].seed  = raw[k*8+6][31:0];
         vecs[k].tsize = raw[k*8+7][`PUT_TSIZE_W-1:0];
      end
      repeat (3) @(posedge clk);
      i_rst_n <= 1'b1;
      @(posedge clk);
      cur = NUM_VEC;
      compare_value("o_req_v", 128'(o_req_v), 128'(0));
      compare_value("put_done_v", 128'(put_done_v), 128'(0));
      compare_value("o_wdata_rsp_v", 128'(o_wdata_rsp_v), 128'(0));
      report_test("reset state", NUM_VEC);
      for (int base = 0; base < NUM_VEC && !timed_out; base += BATCH) begin
         order.delete();
         // a new end beat may meet a request still held in the latch
         for (int k = 0; k < BATCH && !timed_out; k++) begin
            send_transfer(base + k);
         end
         for (int k = 0; k < BATCH && !timed_out; k++) begin
            check_request(base + k);
         end
         // odd batches answer in reverse issue order
         for (int k = 0; k < BATCH && !timed_out; k++) begin
            idx = ((base / BATCH) % 2 == 1) ? base + BATCH - 1 - k : base + k;
            read_back(idx);
            if (k == 0) begin
               send_response(idx, 1'b1);
               @(posedge clk);
               compare_value("put_done_v", 128'(put_done_v), 128'(0));
            end
            send_response(idx, 1'b0);
            order.push_back(idx);
         end
         while (order.size() > 0 && !timed_out) begin
            v = order.pop_front();
            collect_done(v);
            report_test($sformatf("vector %0d tag %0d", v, tag_of[v]), v);
         end
      end
      passed = 0;
      total  = 0;
      for (int k = 0; k <= NUM_VEC; k++) begin
         total += test_err[k];
         if (test_err[k] == 0) begin
            passed++;
         end
      end
      $display("%0d of %0d tests clean, %0d check(s) wrong", passed, NUM_VEC + 1, total);
      if (total == 0 && !timed_out) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/put_engine.sv
// put engine top
// address/data intake, tag pool, data buffer, request issue and response tracking
`default_nettype none

`include "put_macros.svh"

module put_engine (
   input  wire logic                    clk,
   input  wire logic                    i_rst_n,
   input  wire logic                    put_addr_v,
   input  wire put_pkg::put_addr_t      put_addr_d,
   output logic                         put_addr_r,
   input  wire logic                    put_data_v,
   output logic                         put_data_r,
   input  wire logic [`PUT_DATA_W-1:0]  put_data_d,
   input  wire logic                    put_data_e,
   input  wire logic [3:0]              put_data_c,
   output logic                         o_req_v,
   output put_pkg::put_req_t            o_req_d,
   input  wire logic                    o_req_r,
   input  wire logic                    i_rsp_v,
   input  wire put_pkg::put_rsp_t       i_rsp_d,
   input  wire logic                    i_wdata_req_v,
   input  wire put_pkg::put_wdata_req_t i_wdata_req_a,
   output logic                         o_wdata_rsp_v,
   output logic [`PUT_DATA_W-1:0]       o_wdata_rsp_d,
   output logic                         put_done_v,
   output put_pkg::put_done_t           put_done_d,
   input  wire logic                    put_done_r
);

   logic                   tag_v;
   logic [`PUT_TAG_W-1:0]  tag;
   logic                   alloc;
   logic                   free_v;
   logic [`PUT_TAG_W-1:0]  free_tag;
   logic                   wr_v;
   logic [`PUT_TAG_W-1:0]  wr_tag;
   logic [`PUT_BEAT_W-1:0] wr_beat;
   logic [`PUT_DATA_W-1:0] wr_data;
   logic                   cmd_v;
   logic                   cmd_r;
   put_pkg::put_cmd_t      cmd;

   put_tag_pool u_tag_pool (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_alloc(alloc), .o_tag_v(tag_v), .o_tag(tag),
      .i_free_v(free_v), .i_free_tag(free_tag)
   );

   put_data_stage u_data_stage (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_addr_v(put_addr_v), .o_addr_r(put_addr_r), .i_addr(put_addr_d),
      .i_data_v(put_data_v), .o_data_r(put_data_r), .i_data(put_data_d),
      .i_data_e(put_data_e), .i_data_c(put_data_c),
      .i_tag_v(tag_v), .i_tag(tag), .o_alloc(alloc),
      .o_wr_v(wr_v), .o_wr_tag(wr_tag), .o_wr_beat(wr_beat), .o_wr_data(wr_data),
      .o_cmd_v(cmd_v), .o_cmd(cmd), .i_cmd_r(cmd_r)
   );

   put_data_buffer u_data_buffer (
      .clk(clk),
      .i_wr_v(wr_v), .i_wr_tag(wr_tag), .i_wr_beat(wr_beat), .i_wr_data(wr_data),
      .i_rd_v(i_wdata_req_v), .i_rd_a(i_wdata_req_a),
      .o_rd_v(o_wdata_rsp_v), .o_rd_data(o_wdata_rsp_d)
   );

   put_req_issue u_req_issue (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_cmd_v(cmd_v), .i_cmd(cmd), .o_cmd_r(cmd_r),
      .o_req_v(o_req_v), .o_req_d(o_req_d), .i_req_r(o_req_r)
   );

   put_rsp_tracker u_rsp_tracker (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_cmd_v(cmd_v), .i_cmd(cmd),
      .i_rsp_v(i_rsp_v), .i_rsp(i_rsp_d),
      .o_done_v(put_done_v), .o_done(put_done_d), .i_done_r(put_done_r),
      .o_free_v(free_v), .o_free_tag(free_tag)
   );

endmodule

`default_nettype wire

//--- hw/put_rsp_tracker.sv
// put response tracker
// per-tag byte counts, response match, done FIFO and tag release
`default_nettype none

`include "put_macros.svh"

module put_rsp_tracker (
   input  wire logic              clk,
   input  wire logic              i_rst_n,
   input  wire logic              i_cmd_v,
   input  wire put_pkg::put_cmd_t i_cmd,
   input  wire logic              i_rsp_v,
   input  wire put_pkg::put_rsp_t i_rsp,
   output logic                   o_done_v,
   output put_pkg::put_done_t     o_done,
   input  wire logic              i_done_r,
   output logic                   o_free_v,
   output logic [`PUT_TAG_W-1:0]  o_free_tag
);

   logic [`PUT_TSIZE_W-1:0] tsize_tbl [`PUT_NUM_TAGS];
   logic [`PUT_TAG_W-1:0]   fifo_tag [`PUT_NUM_TAGS];
   logic [`PUT_RC_W-1:0]    fifo_rc [`PUT_NUM_TAGS];
   logic [`PUT_TAG_W-1:0]   wr_ptr_q;
   logic [`PUT_TAG_W-1:0]   rd_ptr_q;
   logic [`PUT_TAG_W:0]     count_q;
   logic                    push;
   logic                    pop;
   logic [`PUT_TAG_W-1:0]   head_tag;
   logic [`PUT_RC_W-1:0]    head_rc;

   assign push = i_rsp_v & (i_rsp.uid == `PUT_UID_W'(`PUT_UID));
   assign pop  = o_done_v & i_done_r;

   assign head_tag = fifo_tag[rd_ptr_q];
   assign head_rc  = fifo_rc[rd_ptr_q];

   // a failed put reports no bytes moved
   assign o_done_v    = (count_q != '0);
   assign o_done.rc   = head_rc;
   assign o_done.bcnt = (head_rc == '0) ?
                        {{(`PUT_BCNT_W - `PUT_TSIZE_W){1'b0}}, tsize_tbl[head_tag]} : '0;

   assign o_free_v   = pop;
   assign o_free_tag = head_tag;

   always_ff @(posedge clk) begin
      if (i_cmd_v) begin
         tsize_tbl[i_cmd.tag] <= i_cmd.tsize;
      end
      if (push) begin
         fifo_tag[wr_ptr_q] <= i_rsp.tag;
         fifo_rc[wr_ptr_q]  <= i_rsp.rc;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // one response per tag keeps this within depth
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/put_req_issue.sv
// put request issue
// one-entry latch holding the bus write request
`default_nettype none

`include "put_macros.svh"

module put_req_issue (
   input  wire logic              clk,
   input  wire logic              i_rst_n,
   input  wire logic              i_cmd_v,
   input  wire put_pkg::put_cmd_t i_cmd,
   output logic                   o_cmd_r,
   output logic                   o_req_v,
   output put_pkg::put_req_t      o_req_d,
   input  wire logic              i_req_r
);

   logic full_q;
   logic load;

   // accept when empty or when the held request leaves this cycle
   assign o_cmd_r = ~full_q | i_req_r;
   assign load    = i_cmd_v & o_cmd_r;
   assign o_req_v = full_q;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         full_q <= 1'b0;
      end else if (load) begin
         full_q <= 1'b1;
      end else if (i_req_r) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         o_req_d.uid   <= `PUT_UID_W'(`PUT_UID);
         o_req_d.tag   <= i_cmd.tag;
         o_req_d.tsize <= i_cmd.tsize;
         o_req_d.ctxt  <= i_cmd.addr.ctxt;
         o_req_d.aux   <= i_cmd.addr.aux;
         o_req_d.ea    <= i_cmd.addr.ea;
      end
   end

endmodule

`default_nettype wire

//--- hw/put_data_buffer.sv
// put data buffer
// beats stored by tag and beat, read back by the bus one cycle later
`default_nettype none

`include "put_macros.svh"

module put_data_buffer (
   input  wire logic                    clk,
   input  wire logic                    i_wr_v,
   input  wire logic [`PUT_TAG_W-1:0]   i_wr_tag,
   input  wire logic [`PUT_BEAT_W-1:0]  i_wr_beat,
   input  wire logic [`PUT_DATA_W-1:0]  i_wr_data,
   input  wire logic                    i_rd_v,
   input  wire put_pkg::put_wdata_req_t i_rd_a,
   output logic                         o_rd_v,
   output logic [`PUT_DATA_W-1:0]       o_rd_data
);

   logic [`PUT_DATA_W-1:0] mem [`PUT_NUM_TAGS * `PUT_MAX_BEATS];
   logic                   rd_hit;

   // only reads addressed to this engine are answered
   assign rd_hit = i_rd_v & (i_rd_a.uid == `PUT_UID_W'(`PUT_UID));

   always_ff @(posedge clk) begin
      if (i_wr_v) begin
         mem[{i_wr_tag, i_wr_beat}] <= i_wr_data;
      end
   end

   always_ff @(posedge clk) begin
      o_rd_v <= rd_hit;
      if (rd_hit) begin
         o_rd_data <= mem[{i_rd_a.tag, i_rd_a.beat}];
      end
   end

endmodule

`default_nettype wire

//--- hw/put_data_stage.sv
// put data stage
// takes the address and data beats, fills the buffer and forms the command
`default_nettype none

`include "put_macros.svh"

module put_data_stage (
   input  wire logic                   clk,
   input  wire logic                   i_rst_n,
   input  wire logic                   i_addr_v,
   output logic                        o_addr_r,
   input  wire put_pkg::put_addr_t     i_addr,
   input  wire logic                   i_data_v,
   output logic                        o_data_r,
   input  wire logic [`PUT_DATA_W-1:0] i_data,
   input  wire logic                   i_data_e,
   input  wire logic [3:0]             i_data_c,
   input  wire logic                   i_tag_v,
   input  wire logic [`PUT_TAG_W-1:0]  i_tag,
   output logic                        o_alloc,
   output logic                        o_wr_v,
   output logic [`PUT_TAG_W-1:0]       o_wr_tag,
   output logic [`PUT_BEAT_W-1:0]      o_wr_beat,
   output logic [`PUT_DATA_W-1:0]      o_wr_data,
   output logic                        o_cmd_v,
   output put_pkg::put_cmd_t           o_cmd,
   input  wire logic                   i_cmd_r
);

   typedef enum logic {ST_IDLE, ST_DATA} state_t;

   state_t                  state_q;
   put_pkg::put_addr_t      addr_q;
   logic [`PUT_TAG_W-1:0]   tag_q;
   logic [`PUT_BEAT_W-1:0]  beat_q;
   logic                    addr_xfer;
   logic                    data_xfer;
   logic [4:0]              last_bytes;
   logic [`PUT_TSIZE_W-1:0] full_bytes;

   assign o_addr_r  = (state_q == ST_IDLE) & i_tag_v;
   assign addr_xfer = i_addr_v & o_addr_r;
   assign o_alloc   = addr_xfer;

   // the end beat waits for the request latch
   assign o_data_r  = (state_q == ST_DATA) & (~i_data_e | i_cmd_r);
   assign data_xfer = i_data_v & o_data_r;

   assign o_wr_v    = data_xfer;
   assign o_wr_tag  = tag_q;
   assign o_wr_beat = beat_q;
   assign o_wr_data = i_data;

   // count of zero on the end beat means a full 16 bytes
   assign last_bytes = (i_data_c == 4'd0) ? 5'd16 : {1'b0, i_data_c};
   assign full_bytes = {{(`PUT_TSIZE_W - `PUT_BEAT_W - 4){1'b0}}, beat_q, 4'b0000};

   assign o_cmd_v     = data_xfer & i_data_e;
   assign o_cmd.tag   = tag_q;
   assign o_cmd.tsize = full_bytes + {{(`PUT_TSIZE_W - 5){1'b0}}, last_bytes};
   assign o_cmd.addr  = addr_q;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= ST_IDLE;
         beat_q  <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (addr_xfer) begin
                  state_q <= ST_DATA;
                  beat_q  <= '0;
               end
            end
            ST_DATA: begin
               if (data_xfer) begin
                  beat_q <= beat_q + 1'b1;
                  if (i_data_e) begin
                     state_q <= ST_IDLE;
                  end
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (addr_xfer) begin
         addr_q <= i_addr;
         tag_q  <= i_tag;
      end
   end

endmodule

`default_nettype wire

//--- hw/put_tag_pool.sv
// put tag pool
// free bitmap offering the lowest free local tag
`default_nettype none

`include "put_macros.svh"

module put_tag_pool (
   input  wire logic                  clk,
   input  wire logic                  i_rst_n,
   input  wire logic                  i_alloc,
   output logic                       o_tag_v,
   output logic [`PUT_TAG_W-1:0]      o_tag,
   input  wire logic                  i_free_v,
   input  wire logic [`PUT_TAG_W-1:0] i_free_tag
);

   logic [`PUT_NUM_TAGS-1:0] free_q;
   logic [`PUT_TAG_W-1:0]    pick;

   // priority pick, walking down so the lowest free tag wins
   always_comb begin
      pick = '0;
      for (int i = `PUT_NUM_TAGS - 1; i >= 0; i--) begin
         if (free_q[i]) begin
            pick = `PUT_TAG_W'(i);
         end
      end
   end

   assign o_tag_v = |free_q;
   assign o_tag   = pick;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         free_q <= '1;
      end else begin
         if (i_alloc) begin
            free_q[pick] <= 1'b0;
         end
         // a freed tag is never the one being allocated
         if (i_free_v) begin
            free_q[i_free_tag] <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/put_pkg.sv
// put engine shared types
// address, command, bus request/response and done words
`default_nettype none

`include "put_macros.svh"

package put_pkg;

   typedef struct packed {
      logic [`PUT_AUX_W-1:0]  aux;
      logic [`PUT_CTXT_W-1:0] ctxt;
      logic [`PUT_EA_W-1:0]   ea;
   } put_addr_t;

   // handed from the data stage to issue and to the tracker
   typedef struct packed {
      logic [`PUT_TAG_W-1:0]   tag;
      logic [`PUT_TSIZE_W-1:0] tsize;
      put_addr_t               addr;
   } put_cmd_t;

   typedef struct packed {
      logic [`PUT_UID_W-1:0]   uid;
      logic [`PUT_TAG_W-1:0]   tag;
      logic [`PUT_TSIZE_W-1:0] tsize;
      logic [`PUT_CTXT_W-1:0]  ctxt;
      logic [`PUT_AUX_W-1:0]   aux;
      logic [`PUT_EA_W-1:0]    ea;
   } put_req_t;

   typedef struct packed {
      logic [`PUT_RC_W-1:0]  rc;
      logic [`PUT_UID_W-1:0] uid;
      logic [`PUT_TAG_W-1:0] tag;
   } put_rsp_t;

   // bus read address into the data buffer
   typedef struct packed {
      logic [`PUT_UID_W-1:0]  uid;
      logic [`PUT_TAG_W-1:0]  tag;
      logic [`PUT_BEAT_W-1:0] beat;
   } put_wdata_req_t;

   typedef struct packed {
      logic [`PUT_RC_W-1:0]   rc;
      logic [`PUT_BCNT_W-1:0] bcnt;
   } put_done_t;

endpackage

`default_nettype wire

//--- include/put_macros.svh
// put engine widths and depths
// shared by the package, the RTL and the testbench
`ifndef PUT_MACROS_SVH
`define PUT_MACROS_SVH

`define PUT_DATA_W    128
`define PUT_EA_W      64
`define PUT_CTXT_W    9
`define PUT_AUX_W     1
`define PUT_UID_W     1
`define PUT_UID       0
`define PUT_TAG_W     3
`define PUT_NUM_TAGS  8
`define PUT_BEAT_W    3
`define PUT_MAX_BEATS 8
`define PUT_TSIZE_W   8
`define PUT_RC_W      1
`define PUT_BCNT_W    25

`endif
